//--- Makefile
# Verilator build and run for the core glue testbench

VERILATOR ?= verilator
TOP       ?= tb_core_glue
FLAGS     ?= --binary --timing --assert
BUILD     ?= obj_dir

SRCS := $(shell grep -v '^+' filelist.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): filelist.f $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f filelist.f

# Output goes to the terminal, the grep decides the status
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "all tests passed"

clean:
	rm -rf $(BUILD)

//--- bench/tb_core_glue.sv
/* Core glue testbench
   Drives downloads, video settings and SNAC pins, with a credit returning memory model */
module tb_core_glue;
	timeunit 1ns;
	timeprecision 1ps;
	import loader_pkg::*;
	import frontend_pkg::*;

	localparam int unsigned CREDITS   = 2;
	localparam int unsigned MAX_CYCLE = 4000;

	logic                 clk_1x;
	logic                 RESET;
	host_xfer_t           host;
	logic                 credit_return;
	video_cfg_t           video_cfg;
	snac_ctrl_t           snac;
	logic [USER_PINS-1:0] user_in;
	logic                 host_wait;
	pif_write_t           pif_wr;
	mem_write_t           cart_wr;
	romcopy_t             romcopy;
	logic                 cart_loaded;
	aspect_t              aspect;
	logic [USER_PINS-1:0] user_out;
	logic                 data_in;

	int unsigned cycle;
	int unsigned errors;
	int unsigned tests_run;
	int unsigned tests_bad;
	int unsigned err_mark;
	logic        pif_mode;
	logic        pif_due;
	logic        loaded_seen;
	int unsigned issued;
	int unsigned returned;
	int unsigned starts;
	logic [ADDR_W-1:0] exp_size;
	logic [41:0]       pif_q[$];
	logic [58:0]       cart_q[$];
	int unsigned       credit_due[$];
	int unsigned       last_due;

	core_glue_top #(.CREDITS(CREDITS)) DUT (.*);

	initial begin
		clk_1x = 1'b0;
		forever #50 clk_1x = ~clk_1x;
	end

	task automatic report_mismatch(
		input string       name,
		input logic [63:0] exp,
		input logic [63:0] got
	);
		errors++;
		$display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, exp, got);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != err_mark) begin
			tests_bad++;
		end
		$display("test %s done, errors %0d", name, errors - err_mark);
		err_mark = errors;
	endtask

	// ==================================================
	// Checkers and memory model
	// ==================================================

	always @(negedge clk_1x) begin
		logic [41:0] pe;
		logic [58:0] ce;
		int unsigned due;
		cycle++;
		assert (pif_wr.valid == pif_due)
			else report_mismatch("pif_wr.valid", pif_due, pif_wr.valid);
		pif_due = pif_mode & host.wr & host.addr[1];
		if (pif_wr.valid && pif_q.size() > 0) begin
			pe = pif_q.pop_front();
			assert (pif_wr.data == pe[31:0])
				else report_mismatch("pif_wr.data", pe[31:0], pif_wr.data);
			assert (pif_wr.addr == pe[41:32])
				else report_mismatch("pif_wr.addr", pe[41:32], pif_wr.addr);
		end
		if (cart_wr.valid) begin
			issued++;
			// Random delay, never ahead of an earlier credit
			due = cycle + $urandom_range(1, 6);
			if (due <= last_due) begin
				due = last_due + 1;
			end
			credit_due.push_back(due);
			last_due = due;
			if (cart_q.size() == 0) begin
				errors++;
				$display("Unexpected cart write at t=%0t", $time);
			end else begin
				ce = cart_q.pop_front();
				assert (cart_wr.data == ce[31:0])
					else report_mismatch("cart_wr.data", ce[31:0], cart_wr.data);
				assert (cart_wr.addr == ce[58:32])
					else report_mismatch("cart_wr.addr", ce[58:32], cart_wr.addr);
			end
		end
		assert (issued - returned <= CREDITS)
			else report_mismatch("outstanding", CREDITS, issued - returned);
		assert (host_wait == (issued - returned == CREDITS))
			else report_mismatch("host_wait", issued - returned == CREDITS, host_wait);
		returned += credit_return;
		if (loaded_seen) begin
			assert (cart_loaded) else report_mismatch("cart_loaded", 1, cart_loaded);
		end
		loaded_seen = loaded_seen | cart_loaded;
		if (romcopy.start) begin
			starts++;
			assert (romcopy.size == exp_size)
				else report_mismatch("romcopy.size", exp_size, romcopy.size);
		end
		if (cycle >= MAX_CYCLE) begin
			$display("Timeout after %0d cycles", cycle);
			$display("tests failed");
			$finish;
		end
	end

	// One credit per cycle at most, in write order
	always @(posedge clk_1x) begin
		if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
			credit_return <= 1'b1;
			void'(credit_due.pop_front());
		end else begin
			credit_return <= 1'b0;
		end
	end

	// ==================================================
	// Stimulus
	// ==================================================

	task automatic host_write(input logic [ADDR_W-1:0] a, input logic [15:0] d);
		@(posedge clk_1x);
		host.addr      <= a;
		host.dout.half <= d;
		host.wr        <= 1'b1;
	endtask

	task automatic host_idle();
		@(posedge clk_1x);
		host.wr <= 1'b0;
	endtask

	task automatic start_download(input logic [7:0] idx);
		@(posedge clk_1x);
		host.download <= 1'b1;
		host.index    <= idx;
		host_idle();
	endtask

	task automatic end_download();
		@(posedge clk_1x);
		host.download <= 1'b0;
		host.wr       <= 1'b0;
		repeat (8) @(posedge clk_1x);
	endtask

	task automatic test_pif();
		logic [ADDR_W-1:0] a;
		logic [15:0]       h1;
		logic [15:0]       h2;
		logic              b6;
		b6 = 1'($urandom);
		start_download({1'b0, b6, 6'd0});
		pif_mode = 1'b1;
		for (int i = 0; i < 12; i++) begin
			a  = ADDR_W'($urandom) & ADDR_W'('h7FC);
			h1 = 16'($urandom);
			h2 = 16'($urandom);
			host_write(a, h1);
			pif_q.push_back({b6, a[10:2], h1[7:0], h1[15:8], h2[7:0], h2[15:8]});
			host_write(a | ADDR_W'(2), h2);
			host_idle();
		end
		end_download();
		pif_mode = 1'b0;
		finish_test("pif_rom");
	endtask

	task automatic test_cart();
		logic [ADDR_W-1:0] a;
		logic [15:0]       h1;
		logic [15:0]       h2;
		start_download({2'b00, idx_cart_gb});
		for (int i = 0; i < 16; i++) begin
			a  = ADDR_W'('h100 + i * 4);
			h1 = 16'($urandom);
			h2 = 16'($urandom);
			do @(negedge clk_1x); while (host_wait);
			cart_q.push_back({a + ADDR_W'(8388608), h2, h1});
			host_write(a, h1);
			host_write(a | ADDR_W'(2), h2);
			host_idle();
		end
		end_download();
		repeat (20) @(posedge clk_1x);
		if (cart_q.size() != 0 || issued != 16 || returned != 16 ||
			starts != 0 || cart_loaded) begin
			errors++;
			$display("Cart stream wrong, %0d writes issued, %0d credits back, %0d starts",
				issued, returned, starts);
		end
		finish_test("cart_credits");
	endtask

	task automatic test_romcopy();
		start_download({2'b00, idx_cart_n64});
		for (int i = 0; i < 6; i++) begin
			exp_size = ADDR_W'($urandom);
			host_write(exp_size, 16'($urandom));
		end
		end_download();
		repeat (4) @(posedge clk_1x);
		if (starts != 1 || !cart_loaded) begin
			errors++;
			$display("ROM copy gave %0d start pulses, cart loaded %0b", starts, cart_loaded);
		end
		finish_test("romcopy");
	endtask

	task automatic test_aspect();
		aspect_t    core;
		aspect_t    exp;
		video_cfg_t cfg;
		core = '{x: 12'd4, y: 12'd3};
		for (int m = 0; m < 32; m++) begin
			for (int c = 0; c < 4; c++) begin
				cfg = '{pal: m[0], crop: 2'(c), ar_mode: m[2:1], fixed_blanks_off: m[3],
					clean_hdmi: m[4]};
				if (cfg.fixed_blanks_off || cfg.clean_hdmi) begin
					core = '{x: 12'd4, y: 12'd3};
				end else if (c == 0) begin
					core = cfg.pal ? aspect_t'{x: 12'd512, y: 12'd387}
						: aspect_t'{x: 12'd512, y: 12'd381};
				end else if (c == 1) begin
					core = cfg.pal ? aspect_t'{x: 12'd1024, y: 12'd731}
						: aspect_t'{x: 12'd1280, y: 12'd889};
				end else if (c == 2) begin
					core = cfg.pal ? aspect_t'{x: 12'd2048, y: 12'd1419}
						: aspect_t'{x: 12'd2560, y: 12'd1714};
				end
				exp = (cfg.ar_mode == 0) ? core
					: aspect_t'{x: 12'(cfg.ar_mode - 1), y: 12'd0};
				@(posedge clk_1x);
				video_cfg <= cfg;
				@(posedge clk_1x);
				@(negedge clk_1x);
				assert (aspect == exp) else report_mismatch("aspect", exp, aspect);
			end
		end
		finish_test("aspect");
	endtask

	task automatic test_snac();
		int unsigned pin;
		int unsigned pin_map[4] = '{1, 0, 5, 4};
		for (int i = 0; i < 16; i++) begin
			pin = pin_map[i % 4];
			@(posedge clk_1x);
			snac    <= '{enable: 1'b1, pad_index: 2'(i), data_out: i[2]};
			user_in <= USER_PINS'($urandom);
			@(posedge clk_1x);
			@(negedge clk_1x);
			assert (user_out[pin] == i[2])
				else report_mismatch("user_out pad pin", i[2], user_out[pin]);
			assert (data_in == user_in[pin])
				else report_mismatch("data_in", user_in[pin], data_in);
			assert (user_out[2] && user_out[3] && user_out[6])
				else report_mismatch("user_out held pins", 7'h4C, user_out);
		end
		@(posedge clk_1x);
		snac.enable <= 1'b0;
		@(posedge clk_1x);
		@(negedge clk_1x);
		assert (user_out == '1) else report_mismatch("user_out", 7'h7F, user_out);
		finish_test("snac");
	endtask

	initial begin
		void'($urandom(68));
		cycle = 0;
		errors = 0;
		tests_run = 0;
		tests_bad = 0;
		err_mark = 0;
		issued = 0;
		returned = 0;
		starts = 0;
		last_due = 0;
		pif_mode = 1'b0;
		pif_due = 1'b0;
		loaded_seen = 1'b0;
		exp_size = '0;
		RESET = 1'b0;
		host = '0;
		credit_return = 1'b0;
		video_cfg = '0;
		snac = '0;
		user_in = '1;
		repeat (8) @(posedge clk_1x);
		RESET <= 1'b1;
		test_pif();
		test_cart();
		test_romcopy();
		test_aspect();
		test_snac();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_bad, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- design/aspect_ratio.sv
/* Aspect ratio select
   Core pair from system type and crop, then fixed or override mode */
module aspect_ratio (
	input  logic                     clk_1x,
	input  logic                     RESET,
	input  frontend_pkg::video_cfg_t video_cfg,
	output frontend_pkg::aspect_t    aspect
);
	import frontend_pkg::*;

	aspect_t    core_ar;
	logic [1:0] ar_mode_q;

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			core_ar   <= ASPECT_4_3;
			ar_mode_q <= '0;
		end else begin
			ar_mode_q <= video_cfg.ar_mode;
			if (video_cfg.fixed_blanks_off || video_cfg.clean_hdmi) begin
				core_ar <= ASPECT_4_3;
			end else if (video_cfg.pal) begin
				case (video_cfg.crop)
					2'd0: core_ar <= '{x: 12'd512, y: 12'd387};
					2'd1: core_ar <= '{x: 12'd1024, y: 12'd731};
					2'd2: core_ar <= '{x: 12'd2048, y: 12'd1419};
					default: core_ar <= core_ar;
				endcase
			end else begin
				// NTSC
				case (video_cfg.crop)
					2'd0: core_ar <= '{x: 12'd512, y: 12'd381};
					2'd1: core_ar <= '{x: 12'd1280, y: 12'd889};
					2'd2: core_ar <= '{x: 12'd2560, y: 12'd1714};
					default: core_ar <= core_ar;
				endcase
			end
		end
	end

	// Nonzero mode selects one of the scaler's own presets
	always_comb begin
		if (ar_mode_q == 2'd0) begin
			aspect = core_ar;
		end else begin
			aspect.x = {10'd0, ar_mode_q - 2'd1};
			aspect.y = 12'd0;
		end
	end

endmodule

//--- design/core_glue_top.sv
/* Core glue top
   Connects the ROM loader, aspect select and SNAC port mux */
module core_glue_top #(
	parameter int unsigned CREDITS = 2
) (
	input  logic                               clk_1x,
	input  logic                               RESET,
	input  loader_pkg::host_xfer_t             host,
	input  logic                               credit_return,
	input  frontend_pkg::video_cfg_t           video_cfg,
	input  frontend_pkg::snac_ctrl_t           snac,
	input  logic [frontend_pkg::USER_PINS-1:0] user_in,
	output logic                               host_wait,
	output loader_pkg::pif_write_t             pif_wr,
	output loader_pkg::mem_write_t             cart_wr,
	output loader_pkg::romcopy_t               romcopy,
	output logic                               cart_loaded,
	output frontend_pkg::aspect_t              aspect,
	output logic [frontend_pkg::USER_PINS-1:0] user_out,
	output logic                               data_in
);

	// Host download unpacking
	rom_loader #(
		.CREDITS(CREDITS)
	) u_rom_loader (
		.clk_1x       (clk_1x),
		.RESET        (RESET),
		.host         (host),
		.credit_return(credit_return),
		.host_wait    (host_wait),
		.pif_wr       (pif_wr),
		.cart_wr      (cart_wr),
		.romcopy      (romcopy),
		.cart_loaded  (cart_loaded)
	);

	aspect_ratio u_aspect_ratio (
		.clk_1x   (clk_1x),
		.RESET    (RESET),
		.video_cfg(video_cfg),
		.aspect   (aspect)
	);

	snac_port_mux u_snac_port_mux (
		.clk_1x  (clk_1x),
		.RESET   (RESET),
		.snac    (snac),
		.user_in (user_in),
		.user_out(user_out),
		.data_in (data_in)
	);

endmodule

//--- design/frontend_pkg.sv
/* Frontend package
   Display settings, aspect pair and SNAC user-port routing */
package frontend_pkg;

	// ==================================================
	// Video
	// ==================================================

	typedef struct packed {
		logic       pal;
		logic [1:0] crop;
		logic [1:0] ar_mode;
		logic       fixed_blanks_off;
		logic       clean_hdmi;
	} video_cfg_t;

	typedef struct packed {
		logic [11:0] x;
		logic [11:0] y;
	} aspect_t;

	localparam aspect_t ASPECT_4_3 = '{x: 12'd4, y: 12'd3};

	// ==================================================
	// SNAC
	// ==================================================

	typedef struct packed {
		logic       enable;
		logic [1:0] pad_index;
		logic       data_out;
	} snac_ctrl_t;

	localparam int unsigned USER_PINS = 7;

	// Pad 0..3 go to pins 1, 0, 5, 4
	localparam logic [3:0][2:0] SNAC_PAD_PIN = {3'd4, 3'd5, 3'd0, 3'd1};

	// Unused pins 2, 3 and 6 stay released
	localparam logic [USER_PINS-1:0] SNAC_HELD_PINS = 7'b100_1100;

endpackage

//--- design/loader_pkg.sv
/* Loader package
   Download index codes, memory base constants and host transfer types */
package loader_pkg;

	// ==================================================
	// Download indexes and memory layout
	// ==================================================

	// Compared against the low six index bits only
	localparam logic [5:0] idx_pifrom   = 6'd0;
	localparam logic [5:0] idx_cart_n64 = 6'd1;
	localparam logic [5:0] idx_cart_gb  = 6'd2;

	localparam int unsigned ADDR_W     = 27;
	localparam int unsigned PIF_ADDR_W = 10;

	// GB cart image sits 8 MB into cart RAM
	localparam logic [ADDR_W-1:0] CARTGB_BASE = ADDR_W'(8388608);

	// ==================================================
	// Transfer types
	// ==================================================

	// One host halfword, read as bytes by PIF and whole by cart
	typedef union packed {
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
		logic [15:0] half;
	} halfword_u;

	typedef struct packed {
		logic              download;
		logic [7:0]        index;
		logic [ADDR_W-1:0] addr;
		halfword_u         dout;
		logic              wr;
	} host_xfer_t;

	typedef struct packed {
		logic                  valid;
		logic [PIF_ADDR_W-1:0] addr;
		logic [31:0]           data;
	} pif_write_t;

	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr;
		logic [31:0]       data;
	} mem_write_t;

	typedef struct packed {
		logic              start;
		logic [ADDR_W-1:0] size;
	} romcopy_t;

endpackage

//--- design/rom_loader.sv
/* ROM loader
   Unpacks host downloads into PIF ROM words, credited cart writes and copy start */
module rom_loader #(
	parameter int unsigned CREDITS = 2
) (
	input  logic                   clk_1x,
	input  logic                   RESET,
	input  loader_pkg::host_xfer_t host,
	input  logic                   credit_return,
	output logic                   host_wait,
	output loader_pkg::pif_write_t pif_wr,
	output loader_pkg::mem_write_t cart_wr,
	output loader_pkg::romcopy_t   romcopy,
	output logic                   cart_loaded
);
	import loader_pkg::*;

	localparam int unsigned CNT_W = $clog2(CREDITS + 1);

	logic                  pif_active;
	logic                  n64_active;
	logic                  gb_active;
	logic                  download_q;
	logic                  copy_pending;
	logic                  copy_start;
	logic [ADDR_W-1:0]     copy_size;

	logic                  pif_valid;
	logic [PIF_ADDR_W-1:0] pif_addr;
	logic [31:0]           pif_data;

	logic                  cart_valid;
	logic [ADDR_W-1:0]     cart_addr;
	logic [31:0]           cart_data;
	logic [CNT_W-1:0]      credit_cnt;

	logic                  pif_first;
	logic                  pif_second;
	logic                  cart_first;
	logic                  cart_issue;
	logic                  download_fall;

	// Word halves are selected by address bit 1
	assign pif_first  = pif_active & host.wr & ~host.addr[1];
	assign pif_second = pif_active & host.wr & host.addr[1];
	assign cart_first = gb_active & host.wr & ~host.addr[1];
	assign cart_issue = gb_active & host.wr & host.addr[1];

	assign download_fall = download_q & ~host.download & (host.index[5:0] == idx_cart_n64);

	// ==================================================
	// Download tracking
	// ==================================================

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pif_active   <= 1'b0;
			n64_active   <= 1'b0;
			gb_active    <= 1'b0;
			download_q   <= 1'b0;
			pif_valid    <= 1'b0;
			cart_valid   <= 1'b0;
			copy_pending <= 1'b0;
			copy_start   <= 1'b0;
			cart_loaded  <= 1'b0;
		end else begin
			pif_active   <= host.download & (host.index[5:0] == idx_pifrom);
			n64_active   <= host.download & (host.index[5:0] == idx_cart_n64);
			gb_active    <= host.download & (host.index[5:0] == idx_cart_gb);
			download_q   <= host.download;
			pif_valid    <= pif_second;
			cart_valid   <= cart_issue;
			// Start lands two cycles after the N64 download ends
			copy_pending <= download_fall;
			copy_start   <= copy_pending;
			if (n64_active) begin
				cart_loaded <= 1'b1;
			end
		end
	end

	// ==================================================
	// Word assembly
	// ==================================================

	always_ff @(posedge clk_1x) begin
		// PIF ROM is byte swapped within each halfword
		if (pif_first) begin
			pif_data[31:24] <= host.dout.bytes.lo;
			pif_data[23:16] <= host.dout.bytes.hi;
			pif_addr        <= {host.index[6], host.addr[10:2]};
		end else if (pif_second) begin
			pif_data[15:8] <= host.dout.bytes.lo;
			pif_data[7:0]  <= host.dout.bytes.hi;
		end

		if (cart_first) begin
			cart_data[15:0] <= host.dout.half;
			cart_addr       <= host.addr + CARTGB_BASE;
		end else if (cart_issue) begin
			cart_data[31:16] <= host.dout.half;
		end

		if (download_fall) begin
			copy_size <= host.addr;
		end
	end

	// Credits are taken as the write issues, so wait rises with the valid
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			credit_cnt <= CNT_W'(CREDITS);
		end else if (cart_issue && !credit_return) begin
			credit_cnt <= credit_cnt - CNT_W'(1);
		end else if (credit_return && !cart_issue) begin
			credit_cnt <= credit_cnt + CNT_W'(1);
		end
	end

	assign host_wait = (credit_cnt == '0);

	assign pif_wr  = '{valid: pif_valid, addr: pif_addr, data: pif_data};
	assign cart_wr = '{valid: cart_valid, addr: cart_addr, data: cart_data};
	assign romcopy = '{start: copy_start, size: copy_size};

endmodule

//--- design/snac_port_mux.sv
/* SNAC port mux
   Drives and samples the user-port pin of the selected pad */
module snac_port_mux (
	input  logic                                 clk_1x,
	input  logic                                 RESET,
	input  frontend_pkg::snac_ctrl_t             snac,
	input  logic [frontend_pkg::USER_PINS-1:0]   user_in,
	output logic [frontend_pkg::USER_PINS-1:0]   user_out,
	output logic                                 data_in
);
	import frontend_pkg::*;

	logic [2:0] pad_pin;

	// Pin of the pad being addressed
	assign pad_pin = SNAC_PAD_PIN[snac.pad_index];

	// ==================================================
	// Pin drive and sample
	// ==================================================

	// Open drain port, a one releases the pin
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			user_out <= '1;
			data_in  <= 1'b1;
		end else if (snac.enable) begin
			// Other pad pins keep their last value
			user_out          <= user_out | SNAC_HELD_PINS;
			user_out[pad_pin] <= snac.data_out;
			data_in           <= user_in[pad_pin];
		end else begin
			user_out <= '1;
		end
	end

endmodule

//--- filelist.f
design/loader_pkg.sv
design/frontend_pkg.sv
design/rom_loader.sv
design/aspect_ratio.sv
design/snac_port_mux.sv
design/core_glue_top.sv
bench/tb_core_glue.sv
